/* sources.f */
+incdir+logic
+incdir+tb
logic/mips_pkg.sv
logic/avalon_master.sv
logic/instr_decoder.sv
logic/alu.sv
logic/reg_file.sv
logic/cpu_control.sv
logic/program_ram.sv
logic/system_top.sv
tb/tb_top.sv

/* run_sim.sh */
#!/bin/sh
# build and run the testbench with Verilator from the project root
set -e
cd "$(dirname "$0")"

verilator --binary --timing --timescale 1ns/100ps \
    --top-module tb_top -f sources.f -o tb_sim

out=$(./obj_dir/tb_sim)
echo "$out"

if echo "$out" | grep -q '^>>> PASS$'; then
    exit 0
else
    exit 1
fi

/* tb/tb_model.svh */
`ifndef TB_MODEL_SVH
`define TB_MODEL_SVH

//////////////////////////////////////////////////
// random numbers
//////////////////////////////////////////////////

word_t rng_state = 32'd5545;
word_t prog [$];                        // program words, first one at byte 4.
word_t model_regs [32];
word_t model_mem [`MIPS_RAM_WORDS];
int    err_count;
int    check_count;

function automatic word_t xorshift32();
    word_t x;
    x = rng_state;
    x = x ^ (x << 13);
    x = x ^ (x >> 17);
    x = x ^ (x << 5);
    rng_state = x;
    return x;
endfunction

function automatic int rand_below(int n);
    return int'(xorshift32() % word_t'(n));
endfunction

function automatic reg_idx_t rand_reg(int lo, int hi);
    return reg_idx_t'(lo + rand_below(hi - lo + 1));
endfunction

// every byte of the word follows from the word index.
function automatic word_t fill_word(int i);
    logic [7:0] a;
    a = 8'(i);
    return {a, ~a, a ^ 8'hC3, {a[3:0], a[7:4]} ^ 8'h5A};
endfunction

//////////////////////////////////////////////////
// program builder
//////////////////////////////////////////////////

function automatic word_t enc_r(reg_idx_t rs, reg_idx_t rt, reg_idx_t rd, funct_t fn);
    return {OP_SPECIAL, rs, rt, rd, 5'd0, fn};
endfunction

function automatic word_t enc_i(opcode_t op, reg_idx_t rs, reg_idx_t rt, logic [15:0] imm);
    return {op, rs, rt, imm};
endfunction

function automatic word_t halt_instr();
    return enc_r(5'd0, 5'd0, 5'd0, FN_JR); // jr $0.
endfunction

function automatic void emit(word_t w);
    prog.push_back(w);
endfunction

// encodings outside the supported subset.
function automatic word_t unknown_instr();
    reg_idx_t rs;
    reg_idx_t rt;
    reg_idx_t rd;
    word_t    w;
    rs = rand_reg(0, 7);
    rt = rand_reg(0, 7);
    rd = rand_reg(0, 7);
    case (rand_below(4))
        0:       w = {6'h0F, rs, rt, 16'(xorshift32())};  // lui.
        1:       w = {6'h0D, rs, rt, 16'(xorshift32())};  // ori.
        2:       w = {6'h00, rs, rt, rd, 5'd0, 6'h22};    // sub.
        default: w = {6'h00, rs, rt, rd, 5'd0, 6'h2A};    // slt.
    endcase
    return w;
endfunction

task automatic seed_regs();
    for (int r = 2; r <= 7; r++) begin
        emit(enc_i(OP_ADDIU, 5'd0, reg_idx_t'(r), 16'(xorshift32())));
    end
endtask

task automatic emit_random_alu(int dest_lo, int dest_hi);
    funct_t   fn;
    reg_idx_t rs;
    reg_idx_t rt;
    reg_idx_t rd;
    rs = rand_reg(0, 7);
    rt = rand_reg(0, 7);
    rd = rand_reg(dest_lo, dest_hi);
    case (rand_below(5))
        0:       fn = FN_ADDU;
        1:       fn = FN_SUBU;
        2:       fn = FN_AND;
        3:       fn = FN_OR;
        default: fn = FN_XOR;
    endcase
    if (rand_below(6) == 0) begin
        emit(enc_i(OP_ADDIU, rs, rd, 16'(xorshift32())));
    end else begin
        emit(enc_r(rs, rt, rd, fn));
    end
endtask

// odd_ops mixes in writes to $0 and unknown encodings.
task automatic build_alu_program(bit odd_ops);
    int count;
    int pick;
    prog.delete();
    seed_regs();
    count = 8 + rand_below(13);
    for (int i = 0; i < count; i++) begin
        pick = odd_ops ? rand_below(4) : 3;
        if (pick == 0) begin
            emit(unknown_instr());
        end else if (pick == 1) begin
            emit_random_alu(0, 0);
        end else begin
            emit_random_alu(2, 7);
        end
    end
    emit(halt_instr());
endtask

task automatic build_mem_program();
    logic [15:0] stored [$];
    logic [15:0] off;
    int          count;
    prog.delete();
    seed_regs();
    count = 8 + rand_below(13);
    for (int i = 0; i < count; i++) begin
        case (rand_below(3))
            0: begin
                off = 16'h0200 + 16'(4 * rand_below(128));
                stored.push_back(off);
                emit(enc_i(OP_SW, 5'd0, rand_reg(2, 7), off));
            end
            1: begin
                if (stored.size() > 0) begin
                    off = stored[rand_below(stored.size())];
                end else begin
                    off = 16'h0200 + 16'(4 * rand_below(128));
                end
                emit(enc_i(OP_LW, 5'd0, 5'd2, off));
            end
            default: emit_random_alu(2, 7);
        endcase
    end
    off = 16'h0200 + 16'(4 * rand_below(128));
    emit(enc_i(OP_SW, 5'd0, rand_reg(3, 7), off)); // last word read back into $2.
    emit(enc_i(OP_LW, 5'd0, 5'd2, off));
    emit(halt_instr());
endtask

//////////////////////////////////////////////////
// reference model and compares
//////////////////////////////////////////////////

function automatic void write_reg(reg_idx_t idx, word_t val);
    if (idx != 5'd0) begin
        model_regs[idx] = val;
    end
endfunction

// one instruction, returns 1 on the halt jump.
function automatic logic model_step(word_t w);
    logic [5:0] op;
    logic [5:0] fn;
    reg_idx_t   rs;
    reg_idx_t   rt;
    reg_idx_t   rd;
    word_t      a;
    word_t      b;
    word_t      addr;
    logic       halt;
    op   = w[31:26];
    fn   = w[5:0];
    rs   = w[25:21];
    rt   = w[20:16];
    rd   = w[15:11];
    a    = model_regs[rs];
    b    = model_regs[rt];
    addr = a + {{16{w[15]}}, w[15:0]};
    halt = 1'b0;
    case (op)
        OP_SPECIAL: begin
            case (fn)
                FN_ADDU: write_reg(rd, a + b);
                FN_SUBU: write_reg(rd, a - b);
                FN_AND:  write_reg(rd, a & b);
                FN_OR:   write_reg(rd, a | b);
                FN_XOR:  write_reg(rd, a ^ b);
                FN_JR:   halt = (a == `MIPS_HALT_ADDR);
                default: ;
            endcase
        end
        OP_ADDIU: write_reg(rt, addr);
        OP_LW:    write_reg(rt, model_mem[addr[9:2]]);
        OP_SW:    model_mem[addr[9:2]] = b;
        default:  ;
    endcase
    return halt;
endfunction

task automatic run_model();
    logic halted;
    halted = 1'b0;
    for (int k = 0; k < prog.size() && !halted; k++) begin
        halted = model_step(prog[k]);
    end
endtask

task automatic check_word(string name, word_t expected, word_t actual);
    check_count++;
    if (actual !== expected) begin
        err_count++;
        $display("ERROR %s: expected 0x%08h, observed 0x%08h at %0t",
                 name, expected, actual, $time);
    end
endtask

task automatic check_flag(string name, logic expected, logic actual);
    check_count++;
    if (actual !== expected) begin
        err_count++;
        $display("ERROR %s: expected 0x%0h, observed 0x%0h at %0t",
                 name, expected, actual, $time);
    end
endtask

`endif

/* tb/tb_top.sv */
module tb_top
    import mips_pkg::*;
();

    timeunit 1ns;
    timeprecision 100ps;

    `include "mips_defs.svh"

    localparam int FALL_LIMIT = 5000; // cycles allowed per program.

    logic       clk = 1'b0;
    logic       rst_n;
    logic       start;
    logic       active;
    word_t      register_v0;
    logic       load_en;
    logic [7:0] load_addr;
    word_t      load_data;
    int         timeouts;

    `include "tb_model.svh"

    system_top UUT (
        .clk         (clk),
        .rst_n       (rst_n),
        .start       (start),
        .active      (active),
        .register_v0 (register_v0),
        .load_en     (load_en),
        .load_addr   (load_addr),
        .load_data   (load_data)
    );

    always #5 clk = ~clk;

    //////////////////////////////////////////////////
    // bus-free helpers
    //////////////////////////////////////////////////

    task automatic next_cycle();
        @(posedge clk);
        #1; // inputs change just after the edge.
    endtask

    task automatic fill_ram();
        for (int i = 0; i < `MIPS_RAM_WORDS; i++) begin
            load_en      = 1'b1;
            load_addr    = 8'(i);
            load_data    = fill_word(i);
            model_mem[i] = fill_word(i);
            next_cycle();
        end
        load_en = 1'b0;
    endtask

    task automatic load_program();
        for (int k = 0; k < prog.size(); k++) begin
            load_en          = 1'b1;
            load_addr        = 8'(k + 1); // word 1 is byte address 4.
            load_data        = prog[k];
            model_mem[k + 1] = prog[k];
            next_cycle();
        end
        load_en = 1'b0;
    endtask

    task automatic run_program(string name);
        int n;
        load_program();
        start = 1'b1;
        next_cycle();
        start = 1'b0;
        check_flag("active", 1'b1, active);
        n = 0;
        while (active === 1'b1 && n < FALL_LIMIT) begin
            next_cycle();
            n++;
        end
        if (active === 1'b1) begin
            timeouts++;
            $display("timeout: the %s did not halt within %0d cycles", name, FALL_LIMIT);
        end else begin
            run_model();
            check_word("register_v0", model_regs[2], register_v0);
        end
    endtask

    //////////////////////////////////////////////////
    // test sequence
    //////////////////////////////////////////////////

    initial begin
        rst_n       = 1'b0;
        start       = 1'b0;
        load_en     = 1'b0;
        load_addr   = '0;
        load_data   = '0;
        err_count   = 0;
        check_count = 0;
        timeouts    = 0;
        for (int r = 0; r < 32; r++) begin
            model_regs[r] = '0;
        end
        repeat (5) @(posedge clk);
        #1;
        rst_n = 1'b1;

        check_flag("active", 1'b0, active);
        check_word("register_v0", '0, register_v0);
        fill_ram();

        // 0xff ^ 0x0f0f.
        prog.delete();
        emit(enc_i(OP_ADDIU, 5'd0, 5'd3, 16'h00FF));
        emit(enc_i(OP_ADDIU, 5'd0, 5'd4, 16'h0F0F));
        emit(enc_r(5'd3, 5'd4, 5'd2, FN_XOR));
        emit(halt_instr());
        run_program("reference program");
        if (timeouts == 0) begin
            check_word("register_v0", 32'h0000_0FF0, register_v0);
        end

        for (int p = 0; p < 20 && timeouts == 0; p++) begin
            build_alu_program(1'b0);
            run_program("random alu program");
        end
        for (int p = 0; p < 10 && timeouts == 0; p++) begin
            build_mem_program();
            run_program("store/load program");
        end
        for (int p = 0; p < 8 && timeouts == 0; p++) begin
            build_alu_program(1'b1);
            run_program("zero-write program");
        end

        // no reset, registers and ram carry over.
        if (timeouts == 0) begin
            prog.delete();
            emit(enc_r(5'd2, 5'd3, 5'd2, FN_ADDU));
            emit(enc_r(5'd2, 5'd7, 5'd2, FN_XOR));
            emit(enc_i(OP_LW, 5'd0, 5'd5, 16'h03FC));
            emit(enc_r(5'd2, 5'd5, 5'd2, FN_SUBU));
            emit(halt_instr());
            run_program("carry-over program");
        end

        $display("tb_top: %0d checks, %0d errors, %0d timeouts",
                 check_count, err_count, timeouts);
        if (err_count == 0 && timeouts == 0) begin
            $display(">>> PASS");
        end else begin
            $display(">>> FAIL");
        end
        $finish;
    end

endmodule

/* logic/system_top.sv */
module system_top
    import mips_pkg::*;
(
    input  logic       clk,
    input  logic       rst_n,
    input  logic       start,
    output logic       active,
    output word_t      register_v0,
    input  logic       load_en,
    input  logic [7:0] load_addr,
    input  word_t      load_data
);

    //////////////////////////////////////////////////
    // interconnect
    //////////////////////////////////////////////////

    word_t      instr;
    reg_idx_t   rs;
    reg_idx_t   rt;
    reg_idx_t   rd;
    word_t      imm;
    alu_op_t    alu_op;
    logic       use_imm;
    logic       is_load;
    logic       is_store;
    logic       is_jr;
    logic       writes_reg;

    word_t      rd_a;
    word_t      rd_b;
    word_t      alu_b;
    word_t      alu_y;
    reg_idx_t   wa;
    logic       we;
    word_t      wd;

    logic       bus_req;
    logic       bus_we;
    word_t      bus_addr;
    word_t      bus_wdata;
    logic       bus_done;
    word_t      bus_rdata;

    word_t      address;   // avalon-mm.
    logic       read;
    logic       write;
    word_t      writedata;
    logic [3:0] byteenable;
    word_t      readdata;
    logic       waitrequest;

    //////////////////////////////////////////////////
    // processor
    //////////////////////////////////////////////////

    cpu_control u_ctrl (
        .clk        (clk),
        .rst_n      (rst_n),
        .start      (start),
        .active     (active),
        .instr      (instr),
        .use_imm    (use_imm),
        .is_load    (is_load),
        .is_store   (is_store),
        .is_jr      (is_jr),
        .writes_reg (writes_reg),
        .rd         (rd),
        .imm        (imm),
        .rd_a       (rd_a),
        .rd_b       (rd_b),
        .alu_y      (alu_y),
        .alu_b      (alu_b),
        .wa         (wa),
        .we         (we),
        .wd         (wd),
        .bus_req    (bus_req),
        .bus_we     (bus_we),
        .bus_addr   (bus_addr),
        .bus_wdata  (bus_wdata),
        .bus_done   (bus_done),
        .bus_rdata  (bus_rdata)
    );

    instr_decoder u_dec (
        .instr      (instr),
        .rs         (rs),
        .rt         (rt),
        .rd         (rd),
        .imm        (imm),
        .alu_op     (alu_op),
        .use_imm    (use_imm),
        .is_load    (is_load),
        .is_store   (is_store),
        .is_jr      (is_jr),
        .writes_reg (writes_reg)
    );

    reg_file u_regs (
        .clk   (clk),
        .rst_n (rst_n),
        .ra_a  (rs),
        .ra_b  (rt),
        .wa    (wa),
        .we    (we),
        .wd    (wd),
        .rd_a  (rd_a),
        .rd_b  (rd_b),
        .v0    (register_v0)
    );

    alu u_alu (
        .a  (rd_a),
        .b  (alu_b),
        .op (alu_op),
        .y  (alu_y)
    );

    //////////////////////////////////////////////////
    // bus and memory
    //////////////////////////////////////////////////

    avalon_master u_bus (
        .clk         (clk),
        .rst_n       (rst_n),
        .bus_req     (bus_req),
        .bus_we      (bus_we),
        .bus_addr    (bus_addr),
        .bus_wdata   (bus_wdata),
        .bus_done    (bus_done),
        .bus_rdata   (bus_rdata),
        .address     (address),
        .read        (read),
        .write       (write),
        .writedata   (writedata),
        .byteenable  (byteenable),
        .readdata    (readdata),
        .waitrequest (waitrequest)
    );

    program_ram u_ram (
        .clk         (clk),
        .rst_n       (rst_n),
        .address     (address),
        .writedata   (writedata),
        .read        (read),
        .write       (write),
        .byteenable  (byteenable),
        .readdata    (readdata),
        .waitrequest (waitrequest),
        .load_en     (load_en),
        .load_addr   (load_addr),
        .load_data   (load_data)
    );

endmodule

/* logic/program_ram.sv */
module program_ram
    import mips_pkg::*;
(
    input  logic       clk,
    input  logic       rst_n,
    // avalon-mm slave.
    input  word_t      address,
    input  word_t      writedata,
    input  logic       read,
    input  logic       write,
    input  logic [3:0] byteenable,
    output word_t      readdata,
    output logic       waitrequest,
    // preload port.
    input  logic       load_en,
    input  logic [7:0] load_addr,
    input  word_t      load_data
);

    `include "mips_defs.svh"

    localparam int IDX_W = $clog2(`MIPS_RAM_WORDS);

    word_t            mem [`MIPS_RAM_WORDS];
    logic [IDX_W-1:0] idx;
    logic             in_range;
    logic             served; // second cycle of an access.

    assign idx         = address[IDX_W+1:2];
    assign in_range    = (address[`MIPS_ADDR_W-1:IDX_W+2] == '0);
    assign waitrequest = (read | write) & ~served;

    // one wait cycle, then the access completes.
    always_ff @(posedge clk) begin
        if (!rst_n) begin
            served <= 1'b0;
        end else begin
            served <= (read | write) & ~served;
        end
    end

    always_ff @(posedge clk) begin
        if (read && !served) begin
            readdata <= in_range ? mem[idx] : '0; // valid in the second cycle.
        end
        if (write && !waitrequest && in_range) begin
            for (int b = 0; b < 4; b++) begin
                if (byteenable[b]) begin
                    mem[idx][8*b +: 8] <= writedata[8*b +: 8];
                end
            end
        end
        // load port last so it wins on the same word.
        if (load_en) begin
            mem[load_addr] <= load_data;
        end
    end

endmodule

/* logic/cpu_control.sv */
module cpu_control
    import mips_pkg::*;
(
    input  logic     clk,
    input  logic     rst_n,
    input  logic     start,
    output logic     active,
    output word_t    instr,
    // decoder.
    input  logic     use_imm,
    input  logic     is_load,
    input  logic     is_store,
    input  logic     is_jr,
    input  logic     writes_reg,
    input  reg_idx_t rd,
    input  word_t    imm,
    // register file and alu.
    input  word_t    rd_a,
    input  word_t    rd_b,
    input  word_t    alu_y,
    output word_t    alu_b,
    output reg_idx_t wa,
    output logic     we,
    output word_t    wd,
    // bus requests.
    output logic     bus_req,
    output logic     bus_we,
    output word_t    bus_addr,
    output word_t    bus_wdata,
    input  logic     bus_done,
    input  word_t    bus_rdata
);

    `include "mips_defs.svh"

    seq_state_t state;
    word_t      pc;
    word_t      result; // alu result, then load data.

    //////////////////////////////////////////////////
    // sequencer
    //////////////////////////////////////////////////

    always_ff @(posedge clk) begin
        if (!rst_n) begin
            state  <= S_IDLE;
            pc     <= '0;
            active <= 1'b0;
        end else begin
            case (state)
                S_IDLE: begin
                    if (start) begin
                        state  <= S_FETCH;
                        pc     <= 32'd4; // programs start at byte 4.
                        active <= 1'b1;
                    end
                end
                S_FETCH: begin
                    if (bus_done) begin
                        state <= S_DECODE;
                        pc    <= pc + 32'd4;
                    end
                end
                S_DECODE:  state <= S_EXECUTE; // operands settle from the register file.
                S_EXECUTE: begin
                    if (is_jr) begin
                        pc <= rd_a;
                        if (rd_a == `MIPS_HALT_ADDR) begin
                            state  <= S_IDLE;
                            active <= 1'b0;
                        end else begin
                            state <= S_FETCH;
                        end
                    end else if (is_load || is_store) begin
                        state <= S_MEMORY;
                    end else if (writes_reg) begin
                        state <= S_WRITEBACK;
                    end else begin
                        state <= S_FETCH;
                    end
                end
                S_MEMORY: begin
                    if (bus_done) begin
                        state <= is_load ? S_WRITEBACK : S_FETCH;
                    end
                end
                S_WRITEBACK: state <= S_FETCH;
                default:     state <= S_IDLE;
            endcase
        end
    end

    // instruction and result registers.
    always_ff @(posedge clk) begin
        if (state == S_FETCH && bus_done) begin
            instr <= bus_rdata;
        end
        if (state == S_EXECUTE) begin
            result <= alu_y;
        end else if (state == S_MEMORY && bus_done) begin
            result <= bus_rdata;
        end
    end

    //////////////////////////////////////////////////
    // datapath selects and bus requests
    //////////////////////////////////////////////////

    assign alu_b = use_imm ? imm : rd_b;

    assign we = (state == S_WRITEBACK) && writes_reg;
    assign wa = rd;
    assign wd = result;

    assign bus_req   = (state == S_FETCH) || (state == S_MEMORY);
    assign bus_we    = (state == S_MEMORY) && is_store;
    assign bus_addr  = (state == S_MEMORY) ? result : pc;
    assign bus_wdata = rd_b; // store data comes from rt.

endmodule

/* logic/reg_file.sv */
module reg_file
    import mips_pkg::*;
(
    input  logic     clk,
    input  logic     rst_n,
    input  reg_idx_t ra_a,
    input  reg_idx_t ra_b,
    input  reg_idx_t wa,
    input  logic     we,
    input  word_t    wd,
    output word_t    rd_a,
    output word_t    rd_b,
    output word_t    v0
);

    word_t regs [32];

    always_ff @(posedge clk) begin
        if (!rst_n) begin
            for (int i = 0; i < 32; i++) begin
                regs[i] <= '0;
            end
        end else if (we && wa != 5'd0) begin
            regs[wa] <= wd; // $zero never changes.
        end
    end

    assign rd_a = regs[ra_a];
    assign rd_b = regs[ra_b];
    assign v0   = regs[2];

endmodule

/* logic/alu.sv */
module alu
    import mips_pkg::*;
(
    input  word_t   a,
    input  word_t   b,
    input  alu_op_t op,
    output word_t   y
);

    // addresses for lw and sw come through the add path as base plus offset.
    always_comb begin
        case (op)
            ALU_ADD: y = a + b; // wraps, no overflow trap.
            ALU_SUB: y = a - b;
            ALU_AND: y = a & b;
            ALU_OR:  y = a | b;
            ALU_XOR: y = a ^ b;
            default: y = '0;
        endcase
    end

endmodule

/* logic/instr_decoder.sv */
module instr_decoder
    import mips_pkg::*;
(
    input  word_t    instr,
    output reg_idx_t rs,
    output reg_idx_t rt,
    output reg_idx_t rd,
    output word_t    imm,
    output alu_op_t  alu_op,
    output logic     use_imm,
    output logic     is_load,
    output logic     is_store,
    output logic     is_jr,
    output logic     writes_reg
);

    opcode_t opcode;
    funct_t  funct;

    assign opcode = opcode_t'(instr[31:26]);
    assign funct  = funct_t'(instr[5:0]);
    assign rs     = instr[25:21];
    assign rt     = instr[20:16];
    assign imm    = {{16{instr[15]}}, instr[15:0]}; // sign extended.

    always_comb begin
        // defaults give a no-op that writes nothing.
        alu_op     = ALU_ADD;
        use_imm    = 1'b0;
        is_load    = 1'b0;
        is_store   = 1'b0;
        is_jr      = 1'b0;
        writes_reg = 1'b0;
        rd         = instr[15:11];
        case (opcode)
            OP_SPECIAL: begin
                writes_reg = 1'b1;
                case (funct)
                    FN_ADDU: alu_op = ALU_ADD;
                    FN_SUBU: alu_op = ALU_SUB;
                    FN_AND:  alu_op = ALU_AND;
                    FN_OR:   alu_op = ALU_OR;
                    FN_XOR:  alu_op = ALU_XOR;
                    FN_JR: begin
                        is_jr      = 1'b1;
                        writes_reg = 1'b0;
                    end
                    default: writes_reg = 1'b0;
                endcase
            end
            OP_ADDIU: begin
                use_imm    = 1'b1;
                writes_reg = 1'b1;
                rd         = instr[20:16]; // i-type writes rt.
            end
            OP_LW: begin
                use_imm    = 1'b1;
                is_load    = 1'b1;
                writes_reg = 1'b1;
                rd         = instr[20:16];
            end
            OP_SW: begin
                use_imm  = 1'b1;
                is_store = 1'b1;
            end
            default: ;
        endcase
    end

endmodule

/* logic/avalon_master.sv */
module avalon_master
    import mips_pkg::*;
(
    input  logic       clk,
    input  logic       rst_n,
    // request side, from the sequencer.
    input  logic       bus_req,
    input  logic       bus_we,
    input  word_t      bus_addr,
    input  word_t      bus_wdata,
    output logic       bus_done,
    output word_t      bus_rdata,
    // avalon-mm master.
    output word_t      address,
    output logic       read,
    output logic       write,
    output word_t      writedata,
    output logic [3:0] byteenable,
    input  word_t      readdata,
    input  logic       waitrequest
);

    logic busy;
    logic xfer_end;

    assign busy       = read | write;
    assign xfer_end   = busy & ~waitrequest; // transfer completes at this edge.
    assign byteenable = 4'b1111;             // word accesses only.

    // control side of the transfer.
    always_ff @(posedge clk) begin
        if (!rst_n) begin
            read     <= 1'b0;
            write    <= 1'b0;
            bus_done <= 1'b0;
        end else begin
            bus_done <= xfer_end;
            if (xfer_end) begin
                read  <= 1'b0;
                write <= 1'b0;
            end else if (bus_req && !busy && !bus_done) begin
                // the request is still high during the done cycle, so skip it.
                read  <= ~bus_we;
                write <= bus_we;
            end
        end
    end

    // address and data held for the whole transfer.
    always_ff @(posedge clk) begin
        if (bus_req && !busy && !bus_done) begin
            address   <= bus_addr;
            writedata <= bus_wdata;
        end
        if (xfer_end && read) begin
            bus_rdata <= readdata; // readdata valid while waitrequest is low.
        end
    end

endmodule

/* logic/mips_pkg.sv */
package mips_pkg;

    `include "mips_defs.svh"

    typedef logic [`MIPS_DATA_W-1:0] word_t;   // data or address word.
    typedef logic [4:0]              reg_idx_t; // register number.

    //////////////////////////////////////////////////
    // instruction encodings
    //////////////////////////////////////////////////

    // primary opcodes, bits 31:26.
    typedef enum logic [5:0] {
        OP_SPECIAL = 6'h00,
        OP_ADDIU   = 6'h09,
        OP_LW      = 6'h23,
        OP_SW      = 6'h2B
    } opcode_t;

    // special function codes, bits 5:0.
    typedef enum logic [5:0] {
        FN_JR   = 6'h08,
        FN_ADDU = 6'h21,
        FN_SUBU = 6'h23,
        FN_AND  = 6'h24,
        FN_OR   = 6'h25,
        FN_XOR  = 6'h26
    } funct_t;

    //////////////////////////////////////////////////
    // datapath and sequencer
    //////////////////////////////////////////////////

    typedef enum logic [2:0] {
        ALU_ADD,
        ALU_SUB,
        ALU_AND,
        ALU_OR,
        ALU_XOR
    } alu_op_t;

    typedef enum logic [2:0] {
        S_IDLE,
        S_FETCH,
        S_DECODE,
        S_EXECUTE,
        S_MEMORY,
        S_WRITEBACK
    } seq_state_t;

endpackage

/* logic/mips_defs.svh */
`ifndef MIPS_DEFS_SVH
`define MIPS_DEFS_SVH

//////////////////////////////////////////////////
// machine widths
//////////////////////////////////////////////////

// data word width in bits.
`define MIPS_DATA_W 32

// byte address width on the Avalon bus.
`define MIPS_ADDR_W 32

//////////////////////////////////////////////////
// memory and program control
//////////////////////////////////////////////////

// ram depth in words, indexed by an 8 bit word index.
`define MIPS_RAM_WORDS 256

// jr to this address ends the program.
`define MIPS_HALT_ADDR 32'h0000_0000

`endif
